// ==== chess_pkg.sv ====
package chess_pkg;

   typedef logic [3:0] piece_t;          // kind in [2:0], black in [3]
   typedef logic [255:0] board_t;        // square n at bits 4n+3 down to 4n
   typedef logic [5:0] square_t;         // row * 8 + column
   typedef logic signed [4:0] coord_t;   // room to step off the board

   typedef enum logic [2:0] {
      KIND_EMPTY  = 3'd0,
      KIND_PAWN   = 3'd1,
      KIND_KNIGHT = 3'd2,
      KIND_BISHOP = 3'd3,
      KIND_ROOK   = 3'd4,
      KIND_QUEEN  = 3'd5,
      KIND_KING   = 3'd6
   } kind_e;

   localparam int BLACK_BIT = 3;
   localparam coord_t PAWN_START_WHITE = 5'sd1;
   localparam coord_t PAWN_START_BLACK = 5'sd6;

   // rook steps in 0..3, bishop steps in 4..7
   localparam coord_t DIR_ROW [8] = '{5'sd0, 5'sd0, 5'sd1, -5'sd1, 5'sd1, 5'sd1, -5'sd1, -5'sd1};
   localparam coord_t DIR_COL [8] = '{5'sd1, -5'sd1, 5'sd0, 5'sd0, 5'sd1, -5'sd1, 5'sd1, -5'sd1};
   localparam coord_t KNIGHT_ROW [8] = '{5'sd2, 5'sd1, -5'sd1, -5'sd2,
                                         -5'sd2, -5'sd1, 5'sd1, 5'sd2};
   localparam coord_t KNIGHT_COL [8] = '{5'sd1, 5'sd2, 5'sd2, 5'sd1,
                                         -5'sd1, -5'sd2, -5'sd2, -5'sd1};

   function automatic kind_e kind_of(piece_t p);
      return kind_e'(p[2:0]);
   endfunction

   function automatic logic is_own(piece_t p, logic white);
      return p[2:0] != 3'd0 && p[BLACK_BIT] == !white;
   endfunction

   function automatic logic is_opp(piece_t p, logic white);
      return p[2:0] != 3'd0 && p[BLACK_BIT] == white;
   endfunction

   function automatic logic on_board(coord_t r, coord_t c);
      return r >= 0 && r <= 7 && c >= 0 && c <= 7;
   endfunction

   function automatic square_t to_square(coord_t r, coord_t c);
      return {r[2:0], c[2:0]};
   endfunction

   function automatic coord_t row_of(square_t s);
      return coord_t'({2'b00, s[5:3]});
   endfunction

   function automatic coord_t col_of(square_t s);
      return coord_t'({2'b00, s[2:0]});
   endfunction

   function automatic piece_t piece_at(board_t b, square_t s);
      return b[{s, 2'b00} +: 4];
   endfunction

   // board after the piece on src moves onto dst and replaces what stood there
   function automatic board_t move_piece(board_t b, square_t src, square_t dst);
      board_t nb;
      nb = b;
      nb[{dst, 2'b00} +: 4] = b[{src, 2'b00} +: 4];
      nb[{src, 2'b00} +: 4] = 4'd0;
      return nb;
   endfunction

endpackage

// ==== movegen_pkg.sv ====
package movegen_pkg;

   localparam int MAX_MOVES = 256;     // depth of the move RAM
   localparam int IDX_BITS = $clog2(MAX_MOVES);

   typedef logic [IDX_BITS-1:0] move_idx_t;
   typedef logic [IDX_BITS:0] move_cnt_t;   // reaches MAX_MOVES when full

   typedef struct packed {
      chess_pkg::board_t board;          // position after the move
      logic capture;
   } move_entry_t;

endpackage

// ==== move_if.sv ====
`timescale 1ns/1ps

// candidate move stream from one generator into the store
interface move_if;

   logic valid;
   movegen_pkg::move_entry_t entry;
   logic ready;
   logic done;                          // scan over and nothing pending

   modport source (
      output valid,
      output entry,
      output done,
      input  ready
   );

   modport sink (
      input  valid,
      input  entry,
      input  done,
      output ready
   );

endinterface

// ==== slider_gen.sv ====
`timescale 1ns/1ps

module slider_gen (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  chess_pkg::board_t board_in,
   input  logic              white_to_move,
   move_if.source            out
);

   typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_RAY, ST_FINISHED} state_e;

   state_e            state;
   chess_pkg::board_t board;
   logic              white;
   chess_pkg::square_t sq;
   logic [2:0]        dir;
   chess_pkg::coord_t ray_row;
   chess_pkg::coord_t ray_col;

   chess_pkg::piece_t  cur_piece;
   chess_pkg::kind_e   cur_kind;
   logic               is_slider;
   logic [2:0]         dir_first;
   logic [2:0]         dir_last;
   chess_pkg::square_t ray_sq;
   chess_pkg::piece_t  tgt_piece;
   logic               tgt_on;

   assign cur_piece = chess_pkg::piece_at(board, sq);
   assign cur_kind = chess_pkg::kind_of(cur_piece);
   assign is_slider = chess_pkg::is_own(cur_piece, white) &&
                      (cur_kind == chess_pkg::KIND_QUEEN ||
                       cur_kind == chess_pkg::KIND_ROOK ||
                       cur_kind == chess_pkg::KIND_BISHOP);
   assign dir_first = (cur_kind == chess_pkg::KIND_BISHOP) ? 3'd4 : 3'd0;
   assign dir_last = (cur_kind == chess_pkg::KIND_ROOK) ? 3'd3 : 3'd7;

   assign ray_sq = chess_pkg::to_square(ray_row, ray_col);
   assign tgt_piece = chess_pkg::piece_at(board, ray_sq);
   assign tgt_on = chess_pkg::on_board(ray_row, ray_col);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         out.valid <= 1'b0;
         out.done <= 1'b0;
      end
      else if (start)
      begin
         board <= board_in;
         white <= white_to_move;
         sq <= '0;
         out.valid <= 1'b0;
         out.done <= 1'b0;
         state <= ST_SCAN;
      end
      else
      begin
         if (out.valid && out.ready)
            out.valid <= 1'b0;
         case (state)
            ST_SCAN:
            begin
               dir <= dir_first;
               ray_row <= chess_pkg::row_of(sq) + chess_pkg::DIR_ROW[dir_first];
               ray_col <= chess_pkg::col_of(sq) + chess_pkg::DIR_COL[dir_first];
               if (is_slider)
                  state <= ST_RAY;
               else if (sq == 6'd63)
                  state <= ST_FINISHED;
               else
                  sq <= sq + 1'b1;
            end
            ST_RAY:
            if (!out.valid || out.ready)   // slot free this cycle
            begin
               if (tgt_on && !chess_pkg::is_own(tgt_piece, white))
               begin
                  out.valid <= 1'b1;
                  out.entry.board <= chess_pkg::move_piece(board, sq, ray_sq);
                  out.entry.capture <= chess_pkg::is_opp(tgt_piece, white);
               end
               if (tgt_on && chess_pkg::kind_of(tgt_piece) == chess_pkg::KIND_EMPTY)
               begin
                  ray_row <= ray_row + chess_pkg::DIR_ROW[dir];
                  ray_col <= ray_col + chess_pkg::DIR_COL[dir];
               end
               else if (dir == dir_last)
               begin
                  if (sq == 6'd63)
                     state <= ST_FINISHED;
                  else
                  begin
                     sq <= sq + 1'b1;
                     state <= ST_SCAN;
                  end
               end
               else
               begin
                  dir <= dir + 1'b1;
                  ray_row <= chess_pkg::row_of(sq) + chess_pkg::DIR_ROW[dir + 3'd1];
                  ray_col <= chess_pkg::col_of(sq) + chess_pkg::DIR_COL[dir + 3'd1];
               end
            end
            ST_FINISHED:
            if (!out.valid)
               out.done <= 1'b1;
            default: ;   // idle until start
         endcase
      end
   end

   a_entry_hold: assert property (@(posedge clk) disable iff (reset)
      out.valid && !out.ready |=> out.valid && $stable(out.entry));

endmodule

// ==== stepper_gen.sv ====
`timescale 1ns/1ps

module stepper_gen (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  chess_pkg::board_t board_in,
   input  logic              white_to_move,
   move_if.source            out
);

   typedef enum logic [2:0] {ST_IDLE, ST_SCAN, ST_STEP, ST_PAWN, ST_FINISHED} state_e;

   state_e             state;
   chess_pkg::board_t  board;
   logic               white;
   chess_pkg::square_t sq;
   logic [2:0]         idx;

   chess_pkg::piece_t  cur_piece;
   chess_pkg::kind_e   cur_kind;
   logic               cur_own;
   logic [2:0]         idx_last;
   chess_pkg::coord_t  adv;
   chess_pkg::coord_t  start_row;
   chess_pkg::coord_t  tgt_row;
   chess_pkg::coord_t  tgt_col;
   chess_pkg::square_t tgt_sq;
   chess_pkg::piece_t  tgt_piece;
   chess_pkg::piece_t  fwd1_piece;
   logic               tgt_on;
   logic               keep;

   assign cur_piece = chess_pkg::piece_at(board, sq);
   assign cur_kind = chess_pkg::kind_of(cur_piece);
   assign cur_own = chess_pkg::is_own(cur_piece, white);
   assign idx_last = (state == ST_PAWN) ? 3'd3 : 3'd7;
   assign adv = white ? 5'sd1 : -5'sd1;
   assign start_row = white ? chess_pkg::PAWN_START_WHITE : chess_pkg::PAWN_START_BLACK;

   // pawn idx 0 steps once, 1 twice, 2 and 3 take the diagonals
   always_comb
   begin
      tgt_row = chess_pkg::row_of(sq);
      tgt_col = chess_pkg::col_of(sq);
      if (state == ST_PAWN)
      begin
         tgt_row = chess_pkg::row_of(sq) + ((idx == 3'd1) ? adv + adv : adv);
         if (idx == 3'd2)
            tgt_col = chess_pkg::col_of(sq) - 5'sd1;
         else if (idx == 3'd3)
            tgt_col = chess_pkg::col_of(sq) + 5'sd1;
      end
      else if (cur_kind == chess_pkg::KIND_KNIGHT)
      begin
         tgt_row = chess_pkg::row_of(sq) + chess_pkg::KNIGHT_ROW[idx];
         tgt_col = chess_pkg::col_of(sq) + chess_pkg::KNIGHT_COL[idx];
      end
      else
      begin
         tgt_row = chess_pkg::row_of(sq) + chess_pkg::DIR_ROW[idx];   // king
         tgt_col = chess_pkg::col_of(sq) + chess_pkg::DIR_COL[idx];
      end
   end

   assign tgt_sq = chess_pkg::to_square(tgt_row, tgt_col);
   assign tgt_piece = chess_pkg::piece_at(board, tgt_sq);
   assign tgt_on = chess_pkg::on_board(tgt_row, tgt_col);
   assign fwd1_piece = chess_pkg::piece_at(board,
                          chess_pkg::to_square(chess_pkg::row_of(sq) + adv, chess_pkg::col_of(sq)));

   always_comb
   begin
      keep = 1'b0;
      if (state == ST_STEP)
         keep = tgt_on && !chess_pkg::is_own(tgt_piece, white);
      else if (state == ST_PAWN)
      begin
         case (idx)
            3'd0: keep = tgt_on && chess_pkg::kind_of(tgt_piece) == chess_pkg::KIND_EMPTY;
            3'd1: keep = chess_pkg::row_of(sq) == start_row &&
                         chess_pkg::kind_of(fwd1_piece) == chess_pkg::KIND_EMPTY &&
                         chess_pkg::kind_of(tgt_piece) == chess_pkg::KIND_EMPTY;
            default: keep = tgt_on && chess_pkg::is_opp(tgt_piece, white);
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         out.valid <= 1'b0;
         out.done <= 1'b0;
      end
      else if (start)
      begin
         board <= board_in;
         white <= white_to_move;
         sq <= '0;
         out.valid <= 1'b0;
         out.done <= 1'b0;
         state <= ST_SCAN;
      end
      else
      begin
         if (out.valid && out.ready)
            out.valid <= 1'b0;
         case (state)
            ST_SCAN:
            begin
               idx <= 3'd0;
               if (cur_own && (cur_kind == chess_pkg::KIND_KNIGHT ||
                               cur_kind == chess_pkg::KIND_KING))
                  state <= ST_STEP;
               else if (cur_own && cur_kind == chess_pkg::KIND_PAWN)
                  state <= ST_PAWN;
               else if (sq == 6'd63)
                  state <= ST_FINISHED;
               else
                  sq <= sq + 1'b1;
            end
            ST_STEP, ST_PAWN:
            if (!out.valid || out.ready)
            begin
               if (keep)
               begin
                  out.valid <= 1'b1;
                  out.entry.board <= chess_pkg::move_piece(board, sq, tgt_sq);
                  out.entry.capture <= chess_pkg::is_opp(tgt_piece, white);
               end
               if (idx == idx_last)
               begin
                  if (sq == 6'd63)
                     state <= ST_FINISHED;
                  else
                  begin
                     sq <= sq + 1'b1;
                     state <= ST_SCAN;
                  end
               end
               else
                  idx <= idx + 1'b1;
            end
            ST_FINISHED:
            if (!out.valid)
               out.done <= 1'b1;
            default: ;   // idle until start
         endcase
      end
   end

   a_target_on_board: assert property (@(posedge clk) disable iff (reset)
      keep |-> tgt_on);

endmodule

// ==== move_store.sv ====
`timescale 1ns/1ps

module move_store (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  logic                   clear_moves,
   input  movegen_pkg::move_idx_t move_index,
   output logic                   start,
   output logic                   moves_ready,
   output movegen_pkg::move_cnt_t move_count,
   output chess_pkg::board_t      board_out,
   output logic                   capture_out,
   move_if.sink                   slide,
   move_if.sink                   step
);

   typedef enum logic [1:0] {ST_IDLE, ST_COLLECT, ST_READY} state_e;

   state_e state;
   logic   slide_grant;
   logic   step_grant;
   logic   wr_en;

   movegen_pkg::move_entry_t wr_entry;
   movegen_pkg::move_entry_t rd_entry;
   movegen_pkg::move_entry_t move_ram [movegen_pkg::MAX_MOVES];

   assign slide_grant = state == ST_COLLECT && slide.valid;
   assign step_grant = state == ST_COLLECT && step.valid && !slide.valid;   // slider wins
   assign slide.ready = slide_grant;
   assign step.ready = step_grant;

   // once the list is full further candidates are taken but dropped
   assign wr_en = (slide_grant || step_grant) && move_count < movegen_pkg::MAX_MOVES;
   assign wr_entry = slide_grant ? slide.entry : step.entry;

   assign moves_ready = state == ST_READY;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         start <= 1'b0;
         move_count <= '0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            ST_IDLE:
            if (board_valid)
            begin
               start <= 1'b1;
               move_count <= '0;
               state <= ST_COLLECT;
            end
            ST_COLLECT:
            begin
               if (wr_en)
                  move_count <= move_count + 1'b1;
               if (!start && slide.done && step.done)   // stale done flags during start
                  state <= ST_READY;
            end
            ST_READY:
            if (clear_moves)
            begin
               move_count <= '0;
               state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         move_ram[move_count[movegen_pkg::IDX_BITS-1:0]] <= wr_entry;
      rd_entry <= move_ram[move_index];
   end

   assign board_out = rd_entry.board;
   assign capture_out = rd_entry.capture;

   a_count_bound: assert property (@(posedge clk) disable iff (reset)
      move_count <= movegen_pkg::MAX_MOVES);

   // a candidate waiting outside collect would never be granted
   a_grant_in_collect: assert property (@(posedge clk) disable iff (reset)
      (slide.valid || step.valid) |-> state == ST_COLLECT);

endmodule

// ==== move_gen_top.sv ====
`timescale 1ns/1ps

module move_gen_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  chess_pkg::board_t      board_in,
   input  logic                   white_to_move,
   input  movegen_pkg::move_idx_t move_index,
   input  logic                   clear_moves,
   output logic                   moves_ready,
   output movegen_pkg::move_cnt_t move_count,
   output chess_pkg::board_t      board_out,
   output logic                   capture_out
);

   logic start;

   move_if slide_if ();
   move_if step_if ();

   slider_gen u_slider_gen (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .board_in      (board_in),
      .white_to_move (white_to_move),
      .out           (slide_if.source)
   );

   stepper_gen u_stepper_gen (
      .clk           (clk),
      .reset         (reset),
      .start         (start),
      .board_in      (board_in),
      .white_to_move (white_to_move),
      .out           (step_if.source)
   );

   move_store u_move_store (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_moves (clear_moves),
      .move_index  (move_index),
      .start       (start),
      .moves_ready (moves_ready),
      .move_count  (move_count),
      .board_out   (board_out),
      .capture_out (capture_out),
      .slide       (slide_if.sink),
      .step        (step_if.sink)
   );

endmodule

// ==== move_model.svh ====
// reference moves of one position with their capture flags and matched marks
chess_pkg::board_t model_board [$];
logic model_capture [$];
logic model_used [$];

localparam int LINE_ROW [8] = '{0, 0, 1, -1, 1, 1, -1, -1};   // orthogonal first, then diagonal
localparam int LINE_COL [8] = '{1, -1, 0, 0, 1, -1, 1, -1};
localparam int JUMP_ROW [8] = '{1, 2, 2, 1, -1, -2, -2, -1};
localparam int JUMP_COL [8] = '{2, 1, -1, -2, -2, -1, 1, 2};

function automatic chess_pkg::piece_t square_value(chess_pkg::board_t b, int r, int c);
   return b[(r * 8 + c) * 4 +: 4];
endfunction

function automatic logic on_grid(int r, int c);
   return r >= 0 && r < 8 && c >= 0 && c < 8;
endfunction

function automatic logic vacant(chess_pkg::piece_t p);
   return p[2:0] == 3'd0;
endfunction

function automatic logic friendly(chess_pkg::piece_t p, logic white);
   return !vacant(p) && (white ? !p[3] : p[3]);
endfunction

function automatic logic hostile(chess_pkg::piece_t p, logic white);
   return !vacant(p) && (white ? p[3] : !p[3]);
endfunction

function automatic void add_expected(chess_pkg::board_t b, int r0, int c0, int r1, int c1);
   chess_pkg::board_t after;
   after = b;
   after[(r1 * 8 + c1) * 4 +: 4] = square_value(b, r0, c0);
   after[(r0 * 8 + c0) * 4 +: 4] = 4'h0;
   model_board.push_back(after);
   model_capture.push_back(!vacant(square_value(b, r1, c1)));
   model_used.push_back(1'b0);
endfunction

function automatic void build_expected(chess_pkg::board_t b, logic white);
   int r;
   int c;
   int tr;
   int tc;
   int fwd;
   chess_pkg::piece_t p;
   model_board.delete();
   model_capture.delete();
   model_used.delete();
   fwd = white ? 1 : -1;
   for (int s = 0; s < 64; s++)
   begin
      r = s / 8;
      c = s % 8;
      p = square_value(b, r, c);
      if (!friendly(p, white))
         continue;
      case (p[2:0])
         3'd3, 3'd4, 3'd5:   // bishop, rook, queen
         for (int d = (p[2:0] == 3'd3) ? 4 : 0; d < ((p[2:0] == 3'd4) ? 4 : 8); d++)
         begin
            tr = r + LINE_ROW[d];
            tc = c + LINE_COL[d];
            while (on_grid(tr, tc) && !friendly(square_value(b, tr, tc), white))
            begin
               add_expected(b, r, c, tr, tc);
               if (hostile(square_value(b, tr, tc), white))
                  break;
               tr = tr + LINE_ROW[d];
               tc = tc + LINE_COL[d];
            end
         end
         3'd2, 3'd6:   // knight, king
         for (int k = 0; k < 8; k++)
         begin
            tr = r + ((p[2:0] == 3'd2) ? JUMP_ROW[k] : LINE_ROW[k]);
            tc = c + ((p[2:0] == 3'd2) ? JUMP_COL[k] : LINE_COL[k]);
            if (on_grid(tr, tc) && !friendly(square_value(b, tr, tc), white))
               add_expected(b, r, c, tr, tc);
         end
         3'd1:
         begin
            if (on_grid(r + fwd, c) && vacant(square_value(b, r + fwd, c)))
               add_expected(b, r, c, r + fwd, c);
            if (r == (white ? 1 : 6) && vacant(square_value(b, r + fwd, c)) &&
                vacant(square_value(b, r + 2 * fwd, c)))
               add_expected(b, r, c, r + 2 * fwd, c);
            for (int dc = -1; dc <= 1; dc += 2)
               if (on_grid(r + fwd, c + dc) && hostile(square_value(b, r + fwd, c + dc), white))
                  add_expected(b, r, c, r + fwd, c + dc);
         end
         default: ;
      endcase
   end
endfunction

// ==== move_gen_tb.sv ====
`timescale 1ns/1ps

module move_gen_tb;

   localparam int JOB_TIMEOUT = 20000;   // cycles
   localparam int RANDOM_BOARDS = 200;
   localparam int BACK_ROW [8] = '{4, 2, 3, 5, 6, 3, 2, 4};

   logic                   clk;
   logic                   reset;
   logic                   board_valid;
   chess_pkg::board_t      board_in;
   logic                   white_to_move;
   movegen_pkg::move_idx_t move_index;
   logic                   clear_moves;
   logic                   moves_ready;
   movegen_pkg::move_cnt_t move_count;
   chess_pkg::board_t      board_out;
   logic                   capture_out;

   int moved_total;      // entries where the watched square was vacated
   int moved_captures;
   int capture_total;

   `include "move_model.svh"

   move_gen_top u_move_gen_top (
      .clk           (clk),
      .reset         (reset),
      .board_valid   (board_valid),
      .board_in      (board_in),
      .white_to_move (white_to_move),
      .move_index    (move_index),
      .clear_moves   (clear_moves),
      .moves_ready   (moves_ready),
      .move_count    (move_count),
      .board_out     (board_out),
      .capture_out   (capture_out)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   task automatic stop_with_failure(string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp)
         stop_with_failure($sformatf("Fail at %0t: %s = %b, expected %b", $time, name, got, exp));
   endtask

   task automatic check_count(string name, movegen_pkg::move_cnt_t got,
                              movegen_pkg::move_cnt_t exp);
      if (got !== exp)
         stop_with_failure($sformatf("Fail at %0t: %s = %0d, expected %0d",
                                     $time, name, got, exp));
   endtask

   // the board must be an unmatched model move, then its capture flag must agree
   task automatic check_entry(chess_pkg::board_t got_board, logic got_cap);
      int hit;
      hit = -1;
      foreach (model_board[j])
         if (hit < 0 && !model_used[j] && model_board[j] == got_board)
            hit = j;
      if (hit < 0)
         stop_with_failure($sformatf("the entry read at %0t is not an unmatched move of the position",
                                     $time));
      else
      begin
         model_used[hit] = 1'b1;
         if (got_cap !== model_capture[hit])
            stop_with_failure($sformatf("Fail at %0t: capture_out = %b, expected %b",
                                        $time, got_cap, model_capture[hit]));
      end
   endtask

   function automatic chess_pkg::board_t with_piece(chess_pkg::board_t b, int sq,
                                                    logic black, int kind);
      chess_pkg::board_t nb;
      nb = b;
      nb[sq * 4 +: 4] = {black, kind[2:0]};
      return nb;
   endfunction

   function automatic chess_pkg::board_t opening_board();
      chess_pkg::board_t b;
      b = '0;
      for (int c = 0; c < 8; c++)
      begin
         b = with_piece(b, c, 1'b0, BACK_ROW[c]);
         b = with_piece(b, 8 + c, 1'b0, 1);
         b = with_piece(b, 48 + c, 1'b1, 1);
         b = with_piece(b, 56 + c, 1'b1, BACK_ROW[c]);
      end
      return b;
   endfunction

   task automatic random_board(output chess_pkg::board_t b, output logic white);
      int pieces;
      do
      begin
         b = '0;
         pieces = 2 + $urandom % 15;
         for (int n = 0; n < pieces; n++)
            b = with_piece(b, $urandom % 64, 1'($urandom % 2), 1 + $urandom % 6);
         white = 1'($urandom % 2);
         build_expected(b, white);
      end
      while (model_board.size() > movegen_pkg::MAX_MOVES);   // keep within the RAM depth
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   endtask

   task automatic run_job(chess_pkg::board_t b, logic white);
      int waited;
      board_in = b;
      white_to_move = white;
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      waited = 0;
      while (!moves_ready && waited < JOB_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!moves_ready)
         stop_with_failure("the job never finished, moves_ready stayed low");
   endtask

   // read every index and match it against a distinct model move
   task automatic check_list(chess_pkg::board_t b, logic white, int watch_sq);
      build_expected(b, white);
      check_count("move_count", move_count, movegen_pkg::move_cnt_t'(model_board.size()));
      moved_total = 0;
      moved_captures = 0;
      capture_total = 0;
      for (int i = 0; i < model_board.size(); i++)
      begin
         move_index = movegen_pkg::move_idx_t'(i);
         @(negedge clk);   // registered read
         check_entry(board_out, capture_out);
         if (capture_out)
            capture_total++;
         if (watch_sq >= 0 && board_out[watch_sq * 4 +: 3] == 3'd0)
         begin
            moved_total++;
            if (capture_out)
               moved_captures++;
         end
      end
   endtask

   task automatic clear_list();
      clear_moves = 1'b1;
      @(negedge clk);
      clear_moves = 1'b0;
      check_flag("moves_ready", moves_ready, 1'b0);
      check_count("move_count", move_count, '0);
   endtask

   initial
   begin
      chess_pkg::board_t b;
      logic w;
      void'($urandom(32'h20d5fa5d));
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      white_to_move = 1'b0;
      move_index = '0;
      clear_moves = 1'b0;
      apply_reset();
      check_flag("moves_ready", moves_ready, 1'b0);
      check_count("move_count", move_count, '0);

      b = with_piece(with_piece('0, 4, 1'b0, 6), 56, 1'b1, 6);   // kings on e1 and a8
      run_job(b, 1'b1);
      check_count("move_count", move_count, 9'd5);
      check_list(b, 1'b1, -1);
      clear_list();
      run_job(b, 1'b0);
      check_count("move_count", move_count, 9'd3);
      check_list(b, 1'b0, -1);
      clear_list();

      b = opening_board();
      run_job(b, 1'b1);
      check_count("move_count", move_count, 9'd20);
      check_list(b, 1'b1, -1);
      check_count("captures", movegen_pkg::move_cnt_t'(capture_total), '0);
      board_in = with_piece(b, 20, 1'b0, 5);   // new board while ready is ignored
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      repeat (4) @(negedge clk);
      check_flag("moves_ready", moves_ready, 1'b1);
      check_list(b, 1'b1, -1);
      clear_list();
      run_job(b, 1'b0);
      check_count("move_count", move_count, 9'd20);
      check_list(b, 1'b0, -1);
      clear_list();

      // rook on d4 boxed in by own pawns
      b = with_piece(with_piece('0, 7, 1'b0, 6), 63, 1'b1, 6);
      b = with_piece(b, 27, 1'b0, 4);
      b = with_piece(with_piece(b, 19, 1'b0, 1), 35, 1'b0, 1);
      b = with_piece(with_piece(b, 26, 1'b0, 1), 28, 1'b0, 1);
      run_job(b, 1'b1);
      check_list(b, 1'b1, 27);
      check_count("rook moves", movegen_pkg::move_cnt_t'(moved_total), '0);
      clear_list();

      // same rook with opponent pawns around it
      b = with_piece(with_piece(b, 19, 1'b1, 1), 35, 1'b1, 1);
      b = with_piece(with_piece(b, 26, 1'b1, 1), 28, 1'b1, 1);
      run_job(b, 1'b1);
      check_list(b, 1'b1, 27);
      check_count("rook moves", movegen_pkg::move_cnt_t'(moved_total), 9'd4);
      check_count("rook captures", movegen_pkg::move_cnt_t'(moved_captures), 9'd4);
      clear_list();

      for (int n = 0; n < RANDOM_BOARDS; n++)
      begin
         random_board(b, w);
         run_job(b, w);
         check_list(b, w, -1);
         clear_list();
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
chess_pkg.sv
movegen_pkg.sv
move_if.sv
slider_gen.sv
stepper_gen.sv
move_store.sv
move_gen_top.sv
move_gen_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= move_gen_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
